//--- project.f
+incdir+include
design/axi_pkg.sv
design/dma_pkg.sv
design/buffer_mem_if.sv
design/buffer_ram.sv
design/stream_fifo.sv
design/axis2axi_in.sv
design/axis_axi_write_top.sv
tests/axi_write_slave.sv
tests/axis2axi_tb.sv

//--- tests/axis2axi_tb.sv
`timescale 1ns/1ns

`include "axis_in_settings.svh"

module axis2axi_tb;

   localparam int NUM_CASES      = 5;
   localparam int TIMEOUT_CYCLES = 2000;

   // Stimulus and expected burst lengths, -1 leaves a length unchecked
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      int                     count;
      int                     gap_pct;
      int                     stall_pct;
      int                     first_len;
      int                     last_len;
      int                     every_len;
   } case_t;

   case_t cases [0:NUM_CASES-1];
   string case_names [0:NUM_CASES-1];

   logic                   clk;
   logic                   rst;
   logic [`AXI_ADDR_W-1:0] config_addr;
   logic                   config_valid;
   logic                   config_ready;
   logic [`AXI_DATA_W-1:0] axis_data;
   logic                   axis_valid;
   logic                   axis_ready;
   logic                   awid;
   logic [`AXI_ADDR_W-1:0] awaddr;
   axi_pkg::axi_len_t      awlen;
   axi_pkg::axi_size_t     awsize;
   axi_pkg::axi_burst_e    awburst;
   logic                   awlock;
   axi_pkg::axi_cache_t    awcache;
   axi_pkg::axi_prot_t     awprot;
   axi_pkg::axi_qos_t      awqos;
   logic                   awvalid;
   logic                   awready;
   logic [`AXI_DATA_W-1:0] wdata;
   logic [`AXI_DATA_W/8-1:0] wstrb;
   logic                   wlast;
   logic                   wvalid;
   logic                   wready;
   axi_pkg::axi_resp_e     bresp;
   logic                   bvalid;
   logic                   bready;
   int                     stall_pct;

   axis_axi_write_top UUT (
      .clk_i (clk), .rst_i (rst),
      .config_addr_i (config_addr), .config_valid_i (config_valid),
      .config_ready_o (config_ready),
      .axis_data_i (axis_data), .axis_valid_i (axis_valid), .axis_ready_o (axis_ready),
      .axi_awid_o (awid), .axi_awaddr_o (awaddr), .axi_awlen_o (awlen),
      .axi_awsize_o (awsize), .axi_awburst_o (awburst), .axi_awlock_o (awlock),
      .axi_awcache_o (awcache), .axi_awprot_o (awprot), .axi_awqos_o (awqos),
      .axi_awvalid_o (awvalid), .axi_awready_i (awready),
      .axi_wdata_o (wdata), .axi_wstrb_o (wstrb), .axi_wlast_o (wlast),
      .axi_wvalid_o (wvalid), .axi_wready_i (wready),
      .axi_bresp_i (bresp), .axi_bvalid_i (bvalid), .axi_bready_o (bready)
   );

   axi_write_slave u_slave (
      .clk_i (clk), .stall_pct_i (stall_pct),
      .awaddr_i (awaddr), .awlen_i (awlen), .awsize_i (awsize), .awburst_i (awburst),
      .awvalid_i (awvalid), .awready_o (awready),
      .wdata_i (wdata), .wlast_i (wlast), .wvalid_i (wvalid), .wready_o (wready),
      .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic fail_run();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      fail_run();
   endtask

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("error %s expected %0h actual %0h", test_name, expected, actual);
         fail_run();
      end
   endtask

   // Row index in the top byte, sequence number in the low half
   function automatic logic [31:0] make_word(input int row, input int seq);
      return {row[7:0], 8'h5a, seq[15:0]};
   endfunction

   task automatic load_cases();
      case_names[0] = "full_bursts";
      cases[0]      = '{16'h0100, 24, 0, 0, 7, 7, 7};
      case_names[1] = "remainder";
      cases[1]      = '{16'h0200, 21, 0, 0, 7, 4, -1};
      case_names[2] = "page_cross";
      cases[2]      = '{16'h0ff8, 20, 0, 0, 1, -1, -1};
      case_names[3] = "gaps_stalls";
      cases[3]      = '{16'h1f40, 60, 30, 40, -1, -1, -1};
      case_names[4] = "heavy_stalls";
      cases[4]      = '{16'h3ff0, 37, 50, 70, -1, -1, -1};
   endtask

   task automatic run_case(input int r);
      int                     sent;
      int                     stuck;
      int                     base_aw;
      int                     base_words;
      int                     len;
      logic                   accepted;
      logic [`AXI_ADDR_W-1:0] exp_addr;
      logic [`AXI_ADDR_W-3:0] widx;
      string                  name;

      name       = case_names[r];
      stall_pct  = cases[r].stall_pct;
      base_aw    = u_slave.aw_count;
      base_words = u_slave.word_count;

      stuck = 0;
      while (!config_ready) begin
         @(posedge clk);
         #1;
         stuck++;
         if (stuck > TIMEOUT_CYCLES) begin
            report_timeout("config_ready_o");
         end
      end
      config_addr  = cases[r].addr;
      config_valid = 1'b1;
      @(posedge clk);
      #1;
      config_valid = 1'b0;

      // Valid stays up until the word is taken
      sent       = 0;
      stuck      = 0;
      axis_valid = int'($urandom % 100) >= cases[r].gap_pct;
      axis_data  = make_word(r, 0);
      while (sent < cases[r].count) begin
         @(posedge clk);
         accepted = axis_valid && axis_ready;
         #1;
         stuck = accepted ? 0 : stuck + 1;
         if (stuck > TIMEOUT_CYCLES) begin
            report_timeout("axis_ready_o");
         end
         if (accepted) begin
            sent++;
         end
         if (accepted || !axis_valid) begin
            axis_valid = (sent < cases[r].count) &&
                         (int'($urandom % 100) >= cases[r].gap_pct);
            axis_data  = make_word(r, sent);
         end
      end

      stuck = 0;
      while (!(u_slave.word_count >= base_words + cases[r].count &&
               u_slave.resp_count == u_slave.aw_count && config_ready)) begin
         @(posedge clk);
         #1;
         stuck++;
         if (stuck > TIMEOUT_CYCLES) begin
            report_timeout("the last write response");
         end
      end

      check_value({name, " word count"}, cases[r].count, u_slave.word_count - base_words);
      check_value({name, " illegal bursts"}, 0, u_slave.illegal_count);
      for (int i = 0; i < cases[r].count; i++) begin
         widx = cases[r].addr[`AXI_ADDR_W-1:2] + i;
         check_value($sformatf("%s word %0d", name, i), make_word(r, i),
                     u_slave.mem_words[widx]);
      end

      // Bursts follow each other with no hole and no overlap
      exp_addr = cases[r].addr;
      for (int k = base_aw; k < u_slave.aw_count; k++) begin
         len = u_slave.aw_len_log[k];
         check_value($sformatf("%s burst %0d addr", name, k), exp_addr, u_slave.aw_addr_log[k]);
         check_value($sformatf("%s burst %0d beats", name, k), len + 1, u_slave.beat_log[k]);
         if (k == base_aw && cases[r].first_len >= 0) begin
            check_value({name, " first len"}, cases[r].first_len, len);
         end
         if (k == u_slave.aw_count - 1 && cases[r].last_len >= 0) begin
            check_value({name, " last len"}, cases[r].last_len, len);
         end
         if (cases[r].every_len >= 0) begin
            check_value($sformatf("%s burst %0d len", name, k), cases[r].every_len, len);
         end
         exp_addr = exp_addr + (len + 1) * 4;
      end
   endtask

   initial begin
      void'($urandom(32'h32d1));
      rst          = 1'b1;
      config_addr  = '0;
      config_valid = 1'b0;
      axis_data    = '0;
      axis_valid   = 1'b0;
      stall_pct    = 0;
      load_cases();
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(posedge clk);
      #1;

      // Idle outputs straight out of reset
      check_value("reset awvalid", 0, awvalid);
      check_value("reset wvalid", 0, wvalid);
      check_value("reset wlast", 0, wlast);
      check_value("reset config_ready", 1, config_ready);
      check_value("reset axis_ready", 1, axis_ready);
      check_value("reset awaddr", 0, awaddr);
      check_value("reset wstrb", 4'hf, wstrb);
      check_value("reset bready", 1, bready);

      // Fixed AW attributes
      check_value("awid", 0, awid);
      check_value("awlock", 0, awlock);
      check_value("awqos", 0, awqos);
      check_value("awcache", axi_pkg::AXI_CACHE_DEFAULT, awcache);
      check_value("awprot", axi_pkg::AXI_PROT_DEFAULT, awprot);

      for (int r = 0; r < NUM_CASES; r++) begin
         run_case(r);
      end
      $display("Everything OK");
      $finish;
   end

endmodule

//--- tests/axi_write_slave.sv
`timescale 1ns/1ns

`include "axis_in_settings.svh"

module axi_write_slave (
   input  logic                   clk_i,
   input  int                     stall_pct_i,
   input  logic [`AXI_ADDR_W-1:0] awaddr_i,
   input  axi_pkg::axi_len_t      awlen_i,
   input  axi_pkg::axi_size_t     awsize_i,
   input  axi_pkg::axi_burst_e    awburst_i,
   input  logic                   awvalid_i,
   output logic                   awready_o,
   input  logic [`AXI_DATA_W-1:0] wdata_i,
   input  logic                   wlast_i,
   input  logic                   wvalid_i,
   output logic                   wready_o,
   output axi_pkg::axi_resp_e     bresp_o,
   output logic                   bvalid_o,
   input  logic                   bready_i
);

   localparam int MEM_WORDS = 2 ** (`AXI_ADDR_W - 2);
   localparam int MAX_LEN   = 2 ** `BURST_W - 1;

   // Written words, plus one log entry per burst
   logic [`AXI_DATA_W-1:0] mem_words [0:MEM_WORDS-1];
   logic [`AXI_ADDR_W-1:0] aw_addr_log [0:255];
   int                     aw_len_log [0:255];
   int                     beat_log [0:255];
   int                     aw_count;
   int                     resp_count;
   int                     word_count;
   int                     illegal_count;

   logic [`AXI_ADDR_W-1:0] next_addr;
   logic                   burst_open;
   logic                   resp_due;
   logic                   b_done;
   int                     beats;

   initial begin
      // Unwritten words read back as a pattern of their own address
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_words[i] = 32'hbad0_0000 | i;
      end
      aw_count      = 0;
      resp_count    = 0;
      word_count    = 0;
      illegal_count = 0;
      beats         = 0;
      next_addr     = '0;
      burst_open    = 1'b0;
      resp_due      = 1'b0;
      awready_o     = 1'b0;
      wready_o      = 1'b0;
      bvalid_o      = 1'b0;
      bresp_o       = axi_pkg::OKAY;
   end

   always @(posedge clk_i) begin
      b_done = bvalid_o && bready_i;
      if (b_done) begin
         resp_count++;
      end
      if (awvalid_i && awready_o) begin
         // Attributes, length and 4 KB page all have to be legal
         if (awsize_i != axi_pkg::AXI_SIZE_WORD || awburst_i != axi_pkg::INCR ||
             int'(awlen_i) > MAX_LEN ||
             int'(awaddr_i[11:0]) + (int'(awlen_i) + 1) * 4 > 4096) begin
            illegal_count++;
         end
         aw_addr_log[aw_count] = awaddr_i;
         aw_len_log[aw_count]  = int'(awlen_i);
         aw_count++;
         next_addr  = awaddr_i;
         beats      = 0;
         burst_open = 1'b1;
      end
      if (wvalid_i && wready_o) begin
         // Data with no open burst
         if (!burst_open) begin
            illegal_count++;
         end
         mem_words[next_addr[`AXI_ADDR_W-1:2]] = wdata_i;
         next_addr = next_addr + 4;
         beats++;
         word_count++;
         if (wlast_i && burst_open) begin
            beat_log[aw_count-1] = beats;
            burst_open = 1'b0;
            resp_due   = 1'b1;
         end
      end
      #1;
      awready_o = int'($urandom % 100) >= stall_pct_i;
      wready_o  = int'($urandom % 100) >= stall_pct_i;
      if (b_done) begin
         bvalid_o = 1'b0;
      end
      if (resp_due) begin
         bvalid_o = 1'b1;
         resp_due = 1'b0;
      end
   end

endmodule

//--- design/axis_axi_write_top.sv
`timescale 1ns/1ns

`include "axis_in_settings.svh"

module axis_axi_write_top (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Configuration
   input  logic [`AXI_ADDR_W-1:0]        config_addr_i,
   input  logic                          config_valid_i,
   output logic                          config_ready_o,

   // Stream input
   input  logic [`AXI_DATA_W-1:0]        axis_data_i,
   input  logic                          axis_valid_i,
   output logic                          axis_ready_o,

   // AXI write address channel
   output logic                          axi_awid_o,
   output logic [`AXI_ADDR_W-1:0]        axi_awaddr_o,
   output axi_pkg::axi_len_t             axi_awlen_o,
   output axi_pkg::axi_size_t            axi_awsize_o,
   output axi_pkg::axi_burst_e           axi_awburst_o,
   output logic                          axi_awlock_o,
   output axi_pkg::axi_cache_t           axi_awcache_o,
   output axi_pkg::axi_prot_t            axi_awprot_o,
   output axi_pkg::axi_qos_t             axi_awqos_o,
   output logic                          axi_awvalid_o,
   input  logic                          axi_awready_i,

   // AXI write data channel
   output logic [`AXI_DATA_W-1:0]        axi_wdata_o,
   output logic [`AXI_DATA_W/8-1:0]      axi_wstrb_o,
   output logic                          axi_wlast_o,
   output logic                          axi_wvalid_o,
   input  logic                          axi_wready_i,

   // AXI write response channel
   input  axi_pkg::axi_resp_e            axi_bresp_i,
   input  logic                          axi_bvalid_i,
   output logic                          axi_bready_o
);

   // Link between the FIFO and its storage
   buffer_mem_if buf_mem ();

   axis2axi_in u_engine (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .config_addr_i  (config_addr_i),
      .config_valid_i (config_valid_i),
      .config_ready_o (config_ready_o),
      .axis_data_i    (axis_data_i),
      .axis_valid_i   (axis_valid_i),
      .axis_ready_o   (axis_ready_o),
      .axi_awid_o     (axi_awid_o),
      .axi_awaddr_o   (axi_awaddr_o),
      .axi_awlen_o    (axi_awlen_o),
      .axi_awsize_o   (axi_awsize_o),
      .axi_awburst_o  (axi_awburst_o),
      .axi_awlock_o   (axi_awlock_o),
      .axi_awcache_o  (axi_awcache_o),
      .axi_awprot_o   (axi_awprot_o),
      .axi_awqos_o    (axi_awqos_o),
      .axi_awvalid_o  (axi_awvalid_o),
      .axi_awready_i  (axi_awready_i),
      .axi_wdata_o    (axi_wdata_o),
      .axi_wstrb_o    (axi_wstrb_o),
      .axi_wlast_o    (axi_wlast_o),
      .axi_wvalid_o   (axi_wvalid_o),
      .axi_wready_i   (axi_wready_i),
      .axi_bresp_i    (axi_bresp_i),
      .axi_bvalid_i   (axi_bvalid_i),
      .axi_bready_o   (axi_bready_o),
      .mem            (buf_mem)
   );

   buffer_ram u_ram (
      .clk_i (clk_i),
      .mem   (buf_mem)
   );

endmodule

//--- design/axis2axi_in.sv
`timescale 1ns/1ns

`include "axis_in_settings.svh"

module axis2axi_in (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Configuration
   input  logic [`AXI_ADDR_W-1:0]        config_addr_i,
   input  logic                          config_valid_i,
   output logic                          config_ready_o,

   // Stream input
   input  logic [`AXI_DATA_W-1:0]        axis_data_i,
   input  logic                          axis_valid_i,
   output logic                          axis_ready_o,

   // AXI write address channel
   output logic                          axi_awid_o,
   output logic [`AXI_ADDR_W-1:0]        axi_awaddr_o,
   output axi_pkg::axi_len_t             axi_awlen_o,
   output axi_pkg::axi_size_t            axi_awsize_o,
   output axi_pkg::axi_burst_e           axi_awburst_o,
   output logic                          axi_awlock_o,
   output axi_pkg::axi_cache_t           axi_awcache_o,
   output axi_pkg::axi_prot_t            axi_awprot_o,
   output axi_pkg::axi_qos_t             axi_awqos_o,
   output logic                          axi_awvalid_o,
   input  logic                          axi_awready_i,

   // AXI write data channel
   output logic [`AXI_DATA_W-1:0]        axi_wdata_o,
   output logic [`AXI_DATA_W/8-1:0]      axi_wstrb_o,
   output logic                          axi_wlast_o,
   output logic                          axi_wvalid_o,
   input  logic                          axi_wready_i,

   // AXI write response channel
   input  axi_pkg::axi_resp_e            axi_bresp_i,
   input  logic                          axi_bvalid_i,
   output logic                          axi_bready_o,

   // Buffer storage
   buffer_mem_if.fifo                    mem
);

   localparam logic [`BURST_W:0] MAX_BEATS = {1'b1, {`BURST_W{1'b0}}};

   dma_pkg::write_state_e state;

   logic [`AXI_ADDR_W-1:0] addr_q;
   logic [`BURST_W-1:0]    len_q;
   logic [`BURST_W-1:0]    beat_cnt;

   logic [`AXI_DATA_W-1:0] fifo_data;
   logic                   fifo_full;
   logic                   fifo_empty;
   logic [`BUFFER_W:0]     fifo_level;

   logic                   normal_burst;
   logic                   last_burst;
   logic                   start_transfer;
   logic                   w_hs;
   logic                   read_next;
   logic                   config_hs;
   logic [`BURST_W:0]      burst_size;
   logic [`BURST_W-1:0]    burst_len_m1;
   logic [12:0]            bytes_to_4k;
   logic [10:0]            words_to_4k;
   logic [`BURST_W:0]      burst_beats;
   logic [`AXI_ADDR_W-1:0] burst_bytes;

   // Fixed attributes, single ID, full word strobes
   assign axi_awid_o    = 1'b0;
   assign axi_awsize_o  = axi_pkg::AXI_SIZE_WORD;
   assign axi_awburst_o = axi_pkg::INCR;
   assign axi_awlock_o  = 1'b0;
   assign axi_awcache_o = axi_pkg::AXI_CACHE_DEFAULT;
   assign axi_awprot_o  = axi_pkg::AXI_PROT_DEFAULT;
   assign axi_awqos_o   = '0;
   assign axi_wstrb_o   = '1;
   assign axi_bready_o  = 1'b1;

   // Channel outputs come straight from state and registers
   assign axi_awvalid_o = (state == dma_pkg::START_TRANSFER);
   assign axi_awaddr_o  = addr_q;
   assign axi_awlen_o   = {{(8-`BURST_W){1'b0}}, len_q};
   assign axi_wvalid_o  = (state == dma_pkg::TRANSFER);
   assign axi_wdata_o   = fifo_data;
   assign axi_wlast_o   = (state == dma_pkg::TRANSFER) && (beat_cnt == len_q);

   assign axis_ready_o   = !fifo_full;
   assign config_ready_o = (state == dma_pkg::WAIT_DATA) && fifo_empty;
   assign config_hs      = config_valid_i && config_ready_o;

   // Burst start decision
   assign normal_burst   = (fifo_level >= {1'b0, MAX_BEATS});
   assign last_burst     = (fifo_level != '0) && !normal_burst && !axis_valid_i;
   assign start_transfer = (state == dma_pkg::WAIT_DATA) && (normal_burst || last_burst);

   // Words left before the next 4 KB page
   assign bytes_to_4k = 13'h1000 - {1'b0, addr_q[11:0]};
   assign words_to_4k = bytes_to_4k[12:2];

   always_comb begin
      burst_size = '0;
      if (normal_burst) begin
         burst_size = MAX_BEATS;
      end else if (last_burst) begin
         burst_size = fifo_level[`BURST_W:0];
      end
      if (words_to_4k < {{(11-`BURST_W-1){1'b0}}, burst_size}) begin
         burst_size = words_to_4k[`BURST_W:0];
      end
   end

   // A full burst wraps the low bits to zero, so minus one still gives the max length
   assign burst_len_m1 = burst_size[`BURST_W-1:0] - 1'b1;

   // First word is fetched during the decision cycle, the rest after each accepted beat
   assign w_hs      = axi_wvalid_o && axi_wready_i;
   assign read_next = w_hs && !axi_wlast_o;

   // Address step after a burst
   assign burst_beats = {1'b0, len_q} + 1'b1;
   assign burst_bytes = {{(`AXI_ADDR_W-`BURST_W-3){1'b0}}, burst_beats, 2'b00};

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state    <= dma_pkg::WAIT_DATA;
         addr_q   <= '0;
         len_q    <= '0;
         beat_cnt <= '0;
      end else begin
         case (state)
            dma_pkg::WAIT_DATA: begin
               beat_cnt <= '0;
               if (config_hs) begin
                  addr_q <= config_addr_i;
               end
               if (start_transfer) begin
                  len_q <= burst_len_m1;
                  state <= dma_pkg::START_TRANSFER;
               end
            end
            dma_pkg::START_TRANSFER: begin
               if (axi_awready_i) begin
                  state <= dma_pkg::TRANSFER;
               end
            end
            dma_pkg::TRANSFER: begin
               if (w_hs) begin
                  if (axi_wlast_o) begin
                     addr_q <= addr_q + burst_bytes;
                     state  <= dma_pkg::WAIT_BRESP;
                  end else begin
                     beat_cnt <= beat_cnt + 1'b1;
                  end
               end
            end
            dma_pkg::WAIT_BRESP: begin
               // Any response code closes the burst
               if (axi_bvalid_i) begin
                  state <= dma_pkg::WAIT_DATA;
               end
            end
            default: begin
               state <= dma_pkg::WAIT_DATA;
            end
         endcase
      end
   end

   stream_fifo u_fifo (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .w_en_i    (axis_valid_i),
      .w_data_i  (axis_data_i),
      .w_full_o  (fifo_full),
      .r_en_i    (start_transfer || read_next),
      .r_data_o  (fifo_data),
      .r_empty_o (fifo_empty),
      .level_o   (fifo_level),
      .mem       (mem)
   );

endmodule

//--- design/stream_fifo.sv
`timescale 1ns/1ns

`include "axis_in_settings.svh"

module stream_fifo (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // Push side
   input  logic                    w_en_i,
   input  logic [`AXI_DATA_W-1:0]  w_data_i,
   output logic                    w_full_o,

   // Pop side, data valid one cycle after r_en_i
   input  logic                    r_en_i,
   output logic [`AXI_DATA_W-1:0]  r_data_o,
   output logic                    r_empty_o,

   // Number of stored words
   output logic [`BUFFER_W:0]      level_o,

   // Storage
   buffer_mem_if.fifo              mem
);

   localparam logic [`BUFFER_W:0] FULL_LEVEL = {1'b1, {`BUFFER_W{1'b0}}};

   logic [`BUFFER_W-1:0] w_ptr;
   logic [`BUFFER_W-1:0] r_ptr;
   logic [`BUFFER_W:0]   level;
   logic                 push;
   logic                 pop;

   assign w_full_o  = (level == FULL_LEVEL);
   assign r_empty_o = (level == '0);
   assign level_o   = level;

   // Requests against full or empty are dropped here
   assign push = w_en_i && !w_full_o;
   assign pop  = r_en_i && !r_empty_o;

   // RAM port mapping
   assign mem.w_en   = push;
   assign mem.w_addr = w_ptr;
   assign mem.w_data = w_data_i;
   assign mem.r_en   = pop;
   assign mem.r_addr = r_ptr;
   assign r_data_o   = mem.r_data;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_ptr <= '0;
         r_ptr <= '0;
         level <= '0;
      end else begin
         if (push) begin
            w_ptr <= w_ptr + 1'b1;
         end
         if (pop) begin
            r_ptr <= r_ptr + 1'b1;
         end

         // Simultaneous push and pop leaves the level alone
         case ({push, pop})
            2'b10: begin
               level <= level + 1'b1;
            end
            2'b01: begin
               level <= level - 1'b1;
            end
            default: begin
               level <= level;
            end
         endcase
      end
   end

endmodule

//--- design/buffer_ram.sv
`timescale 1ns/1ns

`include "axis_in_settings.svh"

module buffer_ram (
   input logic        clk_i,
   buffer_mem_if.ram  mem
);

   localparam int unsigned DEPTH = 2 ** `BUFFER_W;

   logic [`AXI_DATA_W-1:0] storage [0:DEPTH-1];

   // Write side
   always_ff @(posedge clk_i) begin
      if (mem.w_en) begin
         storage[mem.w_addr] <= mem.w_data;
      end
   end

   // Registered read, output holds between reads
   always_ff @(posedge clk_i) begin
      if (mem.r_en) begin
         mem.r_data <= storage[mem.r_addr];
      end
   end

endmodule

//--- design/buffer_mem_if.sv
`timescale 1ns/1ns

`include "axis_in_settings.svh"

interface buffer_mem_if;

   // Write port
   logic                  w_en;
   logic [`BUFFER_W-1:0]  w_addr;
   logic [`AXI_DATA_W-1:0] w_data;

   // Read port, data follows r_en by one cycle
   logic                  r_en;
   logic [`BUFFER_W-1:0]  r_addr;
   logic [`AXI_DATA_W-1:0] r_data;

   modport fifo (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   modport ram (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

//--- design/dma_pkg.sv
package dma_pkg;

   // Write engine states
   // WAIT_DATA       idle, decides when a burst can start
   // START_TRANSFER  address phase on AW
   // TRANSFER        data beats on W
   // WAIT_BRESP      burst done, waiting on B
   typedef enum logic [1:0] {
      WAIT_DATA      = 2'd0,
      START_TRANSFER = 2'd1,
      TRANSFER       = 2'd2,
      WAIT_BRESP     = 2'd3
   } write_state_e;

endpackage

//--- design/axi_pkg.sv
package axi_pkg;

   // Burst type on AWBURST
   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } axi_burst_e;

   // Response code on BRESP
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   typedef logic [7:0] axi_len_t;
   typedef logic [2:0] axi_size_t;
   typedef logic [3:0] axi_cache_t;
   typedef logic [2:0] axi_prot_t;
   typedef logic [3:0] axi_qos_t;

   // Fixed write attributes, 4 byte beats, normal non-cacheable, unprivileged non-secure data
   localparam axi_size_t  AXI_SIZE_WORD     = 3'b010;
   localparam axi_cache_t AXI_CACHE_DEFAULT = 4'b0010;
   localparam axi_prot_t  AXI_PROT_DEFAULT  = 3'b010;

endpackage

//--- include/axis_in_settings.svh
`ifndef AXIS_IN_SETTINGS_SVH
`define AXIS_IN_SETTINGS_SVH

// AXI address and data bus widths
`define AXI_ADDR_W 16
`define AXI_DATA_W 32

// Longest burst is 2**BURST_W beats
`define BURST_W 3

// Buffer holds two full bursts
`define BUFFER_W (`BURST_W + 1)

`endif
